//--- compile.f
src/cipher_pkg.sv
src/key_schedule.sv
src/round_engine.sv
src/block_dispatch.sv
src/cipher_device.sv
tests/cipher_checker.sv
tests/tb_cipher_device.sv

//--- Bender.yml
package:
  name: cipher_device

sources:
  - src/cipher_pkg.sv
  - src/key_schedule.sv
  - src/round_engine.sv
  - src/block_dispatch.sv
  - src/cipher_device.sv
  - target: test
    files:
      - tests/cipher_checker.sv
      - tests/tb_cipher_device.sv

//--- tests/tb_cipher_device.sv
`default_nettype none

module tb_cipher_device;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ENC  = 40;
    localparam int N_DEC  = 40;
    localparam int N_MIX  = 100;
    localparam int N_MIX2 = 30;
    // early encrypt, two keygens and all block requests
    localparam int N_REQ       = 1 + 1 + N_ENC + N_DEC + N_MIX + 1 + N_MIX2;
    localparam int CYCLE_LIMIT = N_REQ * 40 + 2000;
    localparam logic [31:0] SEED = 32'h935ee220;
    localparam int NK = cipher_pkg::NUM_ROUND_KEYS;

    logic clk;
    logic resetn;
    logic in_valid;
    logic in_ready;
    logic out_valid;
    logic out_ready;
    logic check_latency;
    logic ready_random;
    logic timed_out;

    cipher_pkg::mode_t  in_mode;
    cipher_pkg::mode_t  out_mode;
    cipher_pkg::block_t in_data;
    cipher_pkg::block_t out_data;

    // separate generator states for stimulus and sink stalls
    logic [31:0] stim_state;
    logic [31:0] ready_state;

    // model key table and test 2 blocks kept for test 3
    cipher_pkg::block_t key_table [NK];
    cipher_pkg::block_t plain_q [$];
    cipher_pkg::block_t cipher_q [$];

    cipher_device #(
        .NUM_ROUNDS(NK)
    ) u_dut (
        .clk(clk), .resetn(resetn),
        .in_valid(in_valid), .in_ready(in_ready),
        .in_mode(in_mode), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data), .out_mode(out_mode)
    );

    cipher_checker #(
        .CYCLE_LIMIT(CYCLE_LIMIT)
    ) u_checker (
        .clk(clk), .resetn(resetn),
        .in_valid(in_valid), .in_ready(in_ready), .in_mode(in_mode),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data), .out_mode(out_mode),
        .check_latency(check_latency), .timed_out(timed_out)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // n random bits with one generator step each
    task automatic draw_bits(input int n, output cipher_pkg::block_t v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            stim_state = lfsr_next(stim_state);
            v = {v[126:0], stim_state[0]};
        end
    endtask

    function automatic cipher_pkg::block_t rotl(input cipher_pkg::block_t v, input int n);
        return (v << n) | (v >> (128 - n));
    endfunction

    // seed first, then rotate by one and mix the constant
    task automatic load_keys(input cipher_pkg::block_t seed);
        key_table[0] = seed;
        for (int i = 1; i < NK; i++)
            key_table[i] = rotl(key_table[i-1], 1) ^ cipher_pkg::KEYGEN_CONST;
    endtask

    function automatic cipher_pkg::block_t model_encrypt(input cipher_pkg::block_t p);
        cipher_pkg::block_t s;
        s = p;
        for (int i = 0; i < NK; i++)
            s = rotl(s ^ key_table[i], 8);
        return s;
    endfunction

    // right rotation by 8 is left rotation by 120
    function automatic cipher_pkg::block_t model_decrypt(input cipher_pkg::block_t c);
        cipher_pkg::block_t s;
        s = c;
        for (int i = NK - 1; i >= 0; i--)
            s = rotl(s, 120) ^ key_table[i];
        return s;
    endfunction

    // offer one request and return on its accepting edge
    task automatic send(input cipher_pkg::mode_t mode, input cipher_pkg::block_t data);
        in_valid <= 1'b1;
        in_mode  <= mode;
        in_data  <= data;
        do
            @(posedge clk);
        while (!in_ready);
    endtask

    // send plus model update
    task automatic request(input cipher_pkg::mode_t mode, input cipher_pkg::block_t data);
        send(mode, data);
        case (mode)
            cipher_pkg::MODE_ENC:    u_checker.expect_out(model_encrypt(data), mode);
            cipher_pkg::MODE_DEC:    u_checker.expect_out(model_decrypt(data), mode);
            cipher_pkg::MODE_KEYGEN: load_keys(data);
            default:                 ;
        endcase
    endtask

    // encrypt, decrypt and the unused mode but no keygen
    task automatic mixed_requests(input int n);
        cipher_pkg::block_t r;
        cipher_pkg::block_t v;
        cipher_pkg::mode_t m;
        for (int i = 0; i < n; i++)
        begin
            draw_bits(2, r);
            m = cipher_pkg::mode_t'(r[1:0]);
            if (m == cipher_pkg::MODE_KEYGEN)
                m = cipher_pkg::mode_t'(3);
            draw_bits(128, v);
            request(m, v);
        end
        in_valid <= 1'b0;
    endtask

    // polled on the falling edge and returns on a rising one
    task automatic drain();
        while (u_checker.outstanding() != 0)
            @(negedge clk);
        repeat (4) @(posedge clk);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // sink is always ready or follows a random stall pattern
    always @(posedge clk)
    begin
        if (ready_random)
        begin
            ready_state = lfsr_next(ready_state);
            out_ready <= ready_state[0];
        end
        else
            out_ready <= 1'b1;
    end

    initial
    begin : watchdog
        wait (timed_out);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin : main
        cipher_pkg::block_t v;
        stim_state    = SEED;
        ready_state   = SEED;
        resetn        = 1'b0;
        in_valid      = 1'b0;
        in_mode       = cipher_pkg::MODE_ENC;
        in_data       = '0;
        out_ready     = 1'b1;
        check_latency = 1'b0;
        ready_random  = 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        repeat (2) @(posedge clk);

        // no keys yet so encrypt must be held off
        draw_bits(128, v);
        in_valid <= 1'b1;
        in_mode  <= cipher_pkg::MODE_ENC;
        in_data  <= v;
        repeat (50) @(posedge clk);
        in_valid <= 1'b0;
        repeat (20) @(posedge clk);
        u_checker.finish_test("test 1 encrypt before keygen");

        check_latency <= 1'b1;
        draw_bits(128, v);
        request(cipher_pkg::MODE_KEYGEN, v);
        for (int i = 0; i < N_ENC; i++)
        begin
            draw_bits(128, v);
            plain_q.push_back(v);
            cipher_q.push_back(model_encrypt(v));
            request(cipher_pkg::MODE_ENC, v);
        end
        in_valid <= 1'b0;
        drain();
        u_checker.finish_test("test 2 keygen and encrypt");

        // ciphertexts back to their plaintexts
        for (int i = 0; i < N_DEC; i++)
        begin
            send(cipher_pkg::MODE_DEC, cipher_q[i]);
            u_checker.expect_out(plain_q[i], cipher_pkg::MODE_DEC);
        end
        in_valid <= 1'b0;
        drain();
        u_checker.finish_test("test 3 decrypt round trip");

        check_latency <= 1'b0;
        ready_random  <= 1'b1;
        mixed_requests(N_MIX);
        drain();
        u_checker.finish_test("test 4 mixed with back-pressure");

        draw_bits(128, v);
        request(cipher_pkg::MODE_KEYGEN, v);
        mixed_requests(N_MIX2);
        drain();
        u_checker.finish_test("test 5 new key table");

        ready_random <= 1'b0;
        repeat (20) @(posedge clk);
        @(negedge clk);
        u_checker.report_totals();
        if (u_checker.err_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/cipher_checker.sv
`default_nettype none

module cipher_checker #(
    parameter int CYCLE_LIMIT = 10000
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  logic               in_ready,
    input  cipher_pkg::mode_t  in_mode,
    input  logic               out_valid,
    input  logic               out_ready,
    input  cipher_pkg::block_t out_data,
    input  cipher_pkg::mode_t  out_mode,
    input  logic               check_latency,
    output logic               timed_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // accept edge to out_valid rise with the sink always ready
    localparam int OUT_LATENCY = 17;
    // keys are written over this many edges after a keygen accept
    localparam int KEY_LATENCY = 16;

    // expected results in acceptance order, filled by the model
    cipher_pkg::block_t exp_data [$];
    cipher_pkg::mode_t  exp_mode [$];
    // edge count at each encrypt/decrypt acceptance
    int acc_cycle [$];

    int cycle      = 0;
    int err_count  = 0;
    int test_errs  = 0;
    int xfer_count = 0;
    int test_xfers = 0;
    int test_count = 0;

    // last keygen acceptance
    logic kg_seen  = 1'b0;
    int   kg_cycle = 0;

    // output stalled on the previous edge
    logic               hold_pending = 1'b0;
    cipher_pkg::block_t hold_data;
    cipher_pkg::mode_t  hold_mode;

    initial
        timed_out = 1'b0;

    task automatic expect_out(input cipher_pkg::block_t data, input cipher_pkg::mode_t mode);
        exp_data.push_back(data);
        exp_mode.push_back(mode);
    endtask

    function automatic int outstanding();
        return exp_data.size();
    endfunction

    task automatic flag_error();
        err_count = err_count + 1;
        test_errs = test_errs + 1;
    endtask

    // one line per finished test
    task automatic finish_test(input string name);
        $display("%s: %0d transfers, %0d errors", name, test_xfers, test_errs);
        test_count = test_count + 1;
        test_xfers = 0;
        test_errs  = 0;
    endtask

    task automatic report_totals();
        $display("totals: %0d tests, %0d transfers, %0d errors",
                 test_count, xfer_count, err_count);
    endtask

    always @(posedge clk)
    begin : watch
        cipher_pkg::block_t want_data;
        cipher_pkg::mode_t  want_mode;
        int lat;
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT && !timed_out)
        begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            timed_out <= 1'b1;
        end
        if (!resetn)
            hold_pending = 1'b0;
        else
        begin
            // encrypt/decrypt only once a full key table exists
            if (in_valid && in_ready && (in_mode == cipher_pkg::MODE_ENC ||
                in_mode == cipher_pkg::MODE_DEC) &&
                (!kg_seen || cycle - kg_cycle <= KEY_LATENCY))
            begin
                $display("at %0d ns a mode %0d request was accepted before the keys were ready",
                         $time, in_mode);
                flag_error();
            end
            if (in_valid && in_ready)
            begin
                if (in_mode == cipher_pkg::MODE_KEYGEN)
                begin
                    kg_seen  = 1'b1;
                    kg_cycle = cycle;
                end
                else if (in_mode == cipher_pkg::MODE_ENC || in_mode == cipher_pkg::MODE_DEC)
                    acc_cycle.push_back(cycle);
            end
            // stalled output must not move
            if (hold_pending)
            begin
                if (!out_valid)
                begin
                    $display("at %0d ns out_valid dropped while out_ready was low", $time);
                    flag_error();
                end
                else if (out_data !== hold_data)
                begin
                    $display("Fail at %0d ns: out_data expected %h got %h",
                             $time, hold_data, out_data);
                    flag_error();
                end
                else if (out_mode !== hold_mode)
                begin
                    $display("Fail at %0d ns: out_mode expected %0d got %0d",
                             $time, hold_mode, out_mode);
                    flag_error();
                end
            end
            if (out_valid && out_ready)
            begin
                xfer_count = xfer_count + 1;
                test_xfers = test_xfers + 1;
                if (exp_data.size() == 0 || acc_cycle.size() == 0)
                begin
                    $display("at %0d ns an output appeared with no request outstanding", $time);
                    flag_error();
                end
                else
                begin
                    want_data = exp_data.pop_front();
                    want_mode = exp_mode.pop_front();
                    // register loaded one edge before this transfer
                    lat = (cycle - 1) - acc_cycle.pop_front();
                    if (out_data !== want_data)
                    begin
                        $display("Fail at %0d ns: out_data expected %h got %h",
                                 $time, want_data, out_data);
                        flag_error();
                    end
                    if (out_mode !== want_mode)
                    begin
                        $display("Fail at %0d ns: out_mode expected %0d got %0d",
                                 $time, want_mode, out_mode);
                        flag_error();
                    end
                    if (check_latency && lat != OUT_LATENCY)
                    begin
                        $display("Fail at %0d ns: out_valid latency expected %0d got %0d",
                                 $time, OUT_LATENCY, lat);
                        flag_error();
                    end
                end
            end
            hold_pending = out_valid && !out_ready;
            hold_data    = out_data;
            hold_mode    = out_mode;
        end
    end

endmodule

`default_nettype wire

//--- src/cipher_device.sv
`default_nettype none

module cipher_device #(
    parameter int NUM_ROUNDS = cipher_pkg::NUM_ROUND_KEYS
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    output logic               in_ready,
    input  cipher_pkg::mode_t  in_mode,
    input  cipher_pkg::block_t in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output cipher_pkg::block_t out_data,
    output cipher_pkg::mode_t  out_mode
);

    // key schedule link
    logic kg_start;
    logic kg_busy;
    logic keys_valid;

    // engine links
    logic enc_start;
    logic dec_start;
    logic enc_free;
    logic dec_free;
    logic enc_done;
    logic dec_done;
    logic enc_take;
    logic dec_take;

    cipher_pkg::block_t    enc_result;
    cipher_pkg::block_t    dec_result;
    cipher_pkg::key_addr_t enc_addr;
    cipher_pkg::key_addr_t dec_addr;
    cipher_pkg::block_t    enc_key;
    cipher_pkg::block_t    dec_key;

    // in_data doubles as the keygen seed
    key_schedule #(
        .NUM_ROUNDS(NUM_ROUNDS)
    ) u_key_schedule (
        .clk(clk), .resetn(resetn),
        .kg_start(kg_start), .seed(in_data),
        .busy(kg_busy), .keys_valid(keys_valid),
        .enc_addr(enc_addr), .enc_key(enc_key),
        .dec_addr(dec_addr), .dec_key(dec_key)
    );

    round_engine #(
        .DECRYPT(0), .NUM_ROUNDS(NUM_ROUNDS)
    ) u_enc_engine (
        .clk(clk), .resetn(resetn),
        .start(enc_start), .block_in(in_data),
        .free(enc_free), .done(enc_done),
        .result(enc_result), .take(enc_take),
        .key_addr(enc_addr), .round_key(enc_key)
    );

    round_engine #(
        .DECRYPT(1), .NUM_ROUNDS(NUM_ROUNDS)
    ) u_dec_engine (
        .clk(clk), .resetn(resetn),
        .start(dec_start), .block_in(in_data),
        .free(dec_free), .done(dec_done),
        .result(dec_result), .take(dec_take),
        .key_addr(dec_addr), .round_key(dec_key)
    );

    block_dispatch u_block_dispatch (
        .clk(clk), .resetn(resetn),
        .in_valid(in_valid), .in_ready(in_ready), .in_mode(in_mode),
        .kg_start(kg_start), .kg_busy(kg_busy), .keys_valid(keys_valid),
        .enc_start(enc_start), .dec_start(dec_start),
        .enc_free(enc_free), .dec_free(dec_free),
        .enc_done(enc_done), .dec_done(dec_done),
        .enc_result(enc_result), .dec_result(dec_result),
        .enc_take(enc_take), .dec_take(dec_take),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data), .out_mode(out_mode)
    );

endmodule

`default_nettype wire

//--- src/block_dispatch.sv
`default_nettype none

module block_dispatch (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    output logic               in_ready,
    input  cipher_pkg::mode_t  in_mode,
    output logic               kg_start,
    input  logic               kg_busy,
    input  logic               keys_valid,
    output logic               enc_start,
    output logic               dec_start,
    input  logic               enc_free,
    input  logic               dec_free,
    input  logic               enc_done,
    input  logic               dec_done,
    input  cipher_pkg::block_t enc_result,
    input  cipher_pkg::block_t dec_result,
    output logic               enc_take,
    output logic               dec_take,
    output logic               out_valid,
    input  logic               out_ready,
    output cipher_pkg::block_t out_data,
    output cipher_pkg::mode_t  out_mode
);

    logic accept;

    // order queue, 0 = encrypt engine, 1 = decrypt engine
    logic       order_q [2];
    logic [1:0] order_cnt;

    logic push;
    logic pop;
    logic head_done;

    // readiness depends on the mode being offered
    always_comb
    begin
        case (in_mode)
            cipher_pkg::MODE_ENC:    in_ready = keys_valid && !kg_busy && enc_free;
            cipher_pkg::MODE_DEC:    in_ready = keys_valid && !kg_busy && dec_free;
            cipher_pkg::MODE_KEYGEN: in_ready = !kg_busy && enc_free && dec_free;
            // unused mode, swallowed
            default:                 in_ready = 1'b1;
        endcase
    end

    assign accept = in_valid && in_ready;

    // single-cycle start pulses
    assign kg_start  = accept && (in_mode == cipher_pkg::MODE_KEYGEN);
    assign enc_start = accept && (in_mode == cipher_pkg::MODE_ENC);
    assign dec_start = accept && (in_mode == cipher_pkg::MODE_DEC);

    assign push = enc_start || dec_start;

    // only the head engine may feed the output register
    assign head_done = order_q[0] ? dec_done : enc_done;
    assign pop       = (order_cnt != 2'd0) && head_done && (!out_valid || out_ready);

    assign enc_take = pop && !order_q[0];
    assign dec_take = pop && order_q[0];

    // queue bookkeeping
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            order_q[0] <= 1'b0;
            order_q[1] <= 1'b0;
            order_cnt  <= 2'd0;
        end
        else if (pop && push)
        begin
            // shift and refill, count unchanged
            if (order_cnt == 2'd1)
                order_q[0] <= dec_start;
            else
            begin
                order_q[0] <= order_q[1];
                order_q[1] <= dec_start;
            end
        end
        else if (pop)
        begin
            order_q[0] <= order_q[1];
            order_cnt  <= order_cnt - 2'd1;
        end
        else if (push)
        begin
            order_q[order_cnt[0]] <= dec_start;
            order_cnt             <= order_cnt + 2'd1;
        end
    end

    // output register valid flag
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            out_valid <= 1'b0;
        else if (pop)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    // output payload, held until the sink takes it
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            out_data <= order_q[0] ? dec_result : enc_result;
            out_mode <= order_q[0] ? cipher_pkg::MODE_DEC : cipher_pkg::MODE_ENC;
        end
    end

endmodule

`default_nettype wire

//--- src/round_engine.sv
`default_nettype none

module round_engine #(
    parameter int DECRYPT    = 0,
    parameter int NUM_ROUNDS = cipher_pkg::NUM_ROUND_KEYS
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  cipher_pkg::block_t    block_in,
    output logic                  free,
    output logic                  done,
    output cipher_pkg::block_t    result,
    input  logic                  take,
    output cipher_pkg::key_addr_t key_addr,
    input  cipher_pkg::block_t    round_key
);

    localparam int W   = cipher_pkg::BLOCK_W;
    localparam int ROT = cipher_pkg::ROUND_ROT;

    localparam cipher_pkg::key_addr_t LAST = cipher_pkg::key_addr_t'(NUM_ROUNDS - 1);

    // block being worked on, result once done
    cipher_pkg::block_t state;
    cipher_pkg::block_t state_next;
    cipher_pkg::block_t mixed;

    // rounds already applied
    cipher_pkg::key_addr_t rnd;
    cipher_pkg::key_addr_t key_idx;
    logic busy;

    assign free   = !busy && !done;
    assign result = state;

    // key for the next round, first key while idle
    // so it is already registered when start arrives
    assign key_idx  = busy ? rnd + 1'b1 : '0;
    assign key_addr = (DECRYPT != 0) ? LAST - key_idx : key_idx;

    // one round of the light cipher
    always_comb
    begin
        if (DECRYPT != 0)
        begin
            // rotate right, then key
            mixed      = (state >> ROT) | (state << (W - ROT));
            state_next = mixed ^ round_key;
        end
        else
        begin
            // key, then rotate left
            mixed      = state ^ round_key;
            state_next = (mixed << ROT) | (mixed >> (W - ROT));
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            rnd  <= '0;
        end
        else
        begin
            if (start)
            begin
                busy <= 1'b1;
                rnd  <= '0;
            end
            else if (busy)
            begin
                rnd <= rnd + 1'b1;
                // last round lands this edge
                if (rnd == LAST)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
            else if (take)
                done <= 1'b0;
        end
    end

    // payload path
    always_ff @(posedge clk)
    begin
        if (start)
            state <= block_in;
        else if (busy)
            state <= state_next;
    end

endmodule

`default_nettype wire

//--- src/key_schedule.sv
`default_nettype none

module key_schedule #(
    parameter int NUM_ROUNDS = cipher_pkg::NUM_ROUND_KEYS
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 kg_start,
    input  cipher_pkg::block_t   seed,
    output logic                 busy,
    output logic                 keys_valid,
    input  cipher_pkg::key_addr_t enc_addr,
    output cipher_pkg::block_t   enc_key,
    input  cipher_pkg::key_addr_t dec_addr,
    output cipher_pkg::block_t   dec_key
);

    localparam int W = cipher_pkg::BLOCK_W;

    // round-key table written once per keygen
    cipher_pkg::block_t key_table [NUM_ROUNDS];

    // key to be written on the next busy cycle
    cipher_pkg::block_t cur_key;
    // table write pointer
    cipher_pkg::key_addr_t wr_cnt;

    logic last_wr;

    assign last_wr = (wr_cnt == cipher_pkg::key_addr_t'(NUM_ROUNDS - 1));

    // busy window and valid flag
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy       <= 1'b0;
            keys_valid <= 1'b0;
            wr_cnt     <= '0;
        end
        else if (kg_start)
        begin
            // old table is stale from here on
            busy       <= 1'b1;
            keys_valid <= 1'b0;
            wr_cnt     <= '0;
        end
        else if (busy)
        begin
            wr_cnt <= wr_cnt + 1'b1;
            if (last_wr)
            begin
                busy       <= 1'b0;
                keys_valid <= 1'b1;
            end
        end
    end

    // expansion step and table write
    always_ff @(posedge clk)
    begin
        if (kg_start)
            cur_key <= seed;
        else if (busy)
        begin
            key_table[wr_cnt] <= cur_key;
            // rotate left by one, then mix the constant
            cur_key <= {cur_key[W-2:0], cur_key[W-1]} ^ cipher_pkg::KEYGEN_CONST;
        end
    end

    // two registered read ports for the two engines
    always_ff @(posedge clk)
    begin
        enc_key <= key_table[enc_addr];
        dec_key <= key_table[dec_addr];
    end

endmodule

`default_nettype wire

//--- src/cipher_pkg.sv
`default_nettype none

package cipher_pkg;

    // data path width, one cipher block
    localparam int BLOCK_W = 128;

    // round keys in the table, also the round count
    localparam int NUM_ROUND_KEYS = 16;

    // width of a round-key table address
    localparam int KEY_ADDR_W = 4;

    // byte rotation applied by one round
    localparam int ROUND_ROT = 8;

    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [KEY_ADDR_W-1:0] key_addr_t;

    // request mode, value 3 accepted and dropped
    typedef logic [1:0] mode_t;

    localparam mode_t MODE_ENC = 2'd0;
    localparam mode_t MODE_DEC = 2'd1;
    localparam mode_t MODE_KEYGEN = 2'd2;

    // mixed into every key expansion step
    localparam block_t KEYGEN_CONST = 128'h9e37_79b9_7f4a_7c15_f39c_c060_5ced_c834;

endpackage

`default_nettype wire
